/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_proc
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* apb_port.sv */
// apb slave giving the bus access to instruction and data memory while the core is stopped
`timescale 1ns/1ns
`include "cpu_macros.svh"

module apb_port import cpu_pkg::*; (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [`APB_AW-1:0] paddr,
   input  word_t              pwdata,
   input  logic               busy,
   input  word_t              dmem_rdata,
   output word_t              prdata,
   output logic               pready,
   output logic               pslverr,
   output logic               imem_we,
   output logic               dmem_we,
   output imem_addr_t         apb_index,
   output word_t              apb_wdata
);

   logic access;
   logic allowed;
   logic sel_dmem;

   assign access   = psel & penable;
   assign allowed  = access & ~busy;
   assign sel_dmem = paddr[`APB_AW-1];

   // no wait states
   assign pready  = access;
   assign pslverr = access & busy;

   assign imem_we   = allowed & pwrite & ~sel_dmem;
   assign dmem_we   = allowed & pwrite & sel_dmem;
   assign apb_index = paddr[`IMEM_AW-1:0];
   assign apb_wdata = pwdata;

   // instruction memory is write only from the bus, reads return zero
   assign prdata = (allowed & sel_dmem) ? dmem_rdata : '0;

   a_penable_needs_psel : assert property (
      @(posedge clk) disable iff (!rst_n) $rose(penable) |-> psel
   ) else $error("apb: penable rose without psel");

endmodule

/* cpu_macros.svh */
// width, depth and opcode definitions for the pipelined cpu core
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and register file
`define WORD_W    16
`define REG_IDX_W 3

// memories, 256 words each
`define IMEM_AW   8
`define DMEM_AW   8

// apb address, top bit picks data memory
`define APB_AW    9

// opcodes in instruction bits 15 to 11
`define OP_HALT   5'b00000
`define OP_NOP    5'b00001
`define OP_ADDI   5'b01000
`define OP_ST     5'b10000
`define OP_LD     5'b10001
`define OP_LBI    5'b11000
`define OP_ALU    5'b11011

`endif

/* cpu_pkg.sv */
// shared data types and state encodings of the pipelined cpu core
`include "cpu_macros.svh"

package cpu_pkg;

   typedef logic [`WORD_W-1:0]    word_t;
   typedef logic [`REG_IDX_W-1:0] reg_idx_t;
   typedef logic [`IMEM_AW-1:0]   imem_addr_t;
   typedef logic [`DMEM_AW-1:0]   dmem_addr_t;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_xor,
      alu_and,
      alu_pass_b
   } alu_op_t;

   // operand source for execute
   typedef enum logic [1:0] {
      fwd_rf,
      fwd_mem,
      fwd_wb
   } fwd_sel_t;

   typedef enum logic [1:0] {
      st_idle,
      st_running,
      st_draining,
      st_halted
   } run_state_t;

endpackage

/* decode.sv */
// instruction decoder, register file and the id/ex register
`timescale 1ns/1ns
`include "cpu_macros.svh"

module decode import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     stall,
   input  word_t    id_instr,
   input  logic     id_valid,
   input  logic     wb_we,
   input  reg_idx_t wb_reg,
   input  word_t    wb_data,
   output reg_idx_t rs_idx,
   output reg_idx_t rt_idx,
   output logic     uses_rt,
   output logic     ex_valid,
   output logic     ex_halt,
   output word_t    ex_op_a,
   output word_t    ex_op_b,
   output word_t    ex_imm,
   output alu_op_t  ex_alu_op,
   output logic     ex_use_imm,
   output logic     ex_mem_rd,
   output logic     ex_mem_wr,
   output logic     ex_we,
   output reg_idx_t ex_dst,
   output reg_idx_t ex_rs,
   output reg_idx_t ex_rt,
   output logic     err
);

   word_t      rf [2**`REG_IDX_W];
   logic [4:0] opcode;
   word_t      imm;
   alu_op_t    alu_op;
   logic       use_imm;
   logic       mem_rd;
   logic       mem_wr;
   logic       we;
   logic       halt;
   logic       illegal;
   reg_idx_t   dst;
   word_t      rd_a;
   word_t      rd_b;

   assign opcode = id_instr[15:11];
   assign rs_idx = id_instr[10:8];
   assign rt_idx = id_instr[7:5];

   always_comb begin
      imm     = {{(`WORD_W-5){id_instr[4]}}, id_instr[4:0]};
      alu_op  = alu_add;
      use_imm = 1'b1;
      mem_rd  = 1'b0;
      mem_wr  = 1'b0;
      we      = 1'b0;
      halt    = 1'b0;
      illegal = 1'b0;
      uses_rt = 1'b0;
      dst     = rt_idx;
      case (opcode)
         `OP_HALT: halt = 1'b1;
         `OP_NOP: begin
         end
         `OP_ADDI: we = 1'b1;
         `OP_LD: begin
            mem_rd = 1'b1;
            we     = 1'b1;
         end
         `OP_ST: begin
            mem_wr  = 1'b1;
            uses_rt = 1'b1;
         end
         `OP_LBI: begin
            imm    = {{(`WORD_W-8){id_instr[7]}}, id_instr[7:0]};
            alu_op = alu_pass_b;
            we     = 1'b1;
            dst    = rs_idx;
         end
         `OP_ALU: begin
            use_imm = 1'b0;
            we      = 1'b1;
            uses_rt = 1'b1;
            dst     = id_instr[4:2];
            case (id_instr[1:0])
               2'b00: alu_op = alu_add;
               2'b01: alu_op = alu_sub;
               2'b10: alu_op = alu_xor;
               default: alu_op = alu_and;
            endcase
         end
         // unknown opcode runs as a nop
         default: illegal = 1'b1;
      endcase
      if (!id_valid) begin
         mem_rd  = 1'b0;
         mem_wr  = 1'b0;
         we      = 1'b0;
         halt    = 1'b0;
         illegal = 1'b0;
         uses_rt = 1'b0;
      end
   end

   // write in the same cycle passes straight through
   assign rd_a = (wb_we && wb_reg == rs_idx) ? wb_data : rf[rs_idx];
   assign rd_b = (wb_we && wb_reg == rt_idx) ? wb_data : rf[rt_idx];

   always_ff @(posedge clk) begin
      if (wb_we) begin
         rf[wb_reg] <= wb_data;
      end
   end

   // bubble into id/ex on stall
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_valid  <= 1'b0;
         ex_halt   <= 1'b0;
         ex_mem_rd <= 1'b0;
         ex_mem_wr <= 1'b0;
         ex_we     <= 1'b0;
      end else begin
         ex_valid  <= id_valid & ~stall;
         ex_halt   <= halt & ~stall;
         ex_mem_rd <= mem_rd & ~stall;
         ex_mem_wr <= mem_wr & ~stall;
         ex_we     <= we & ~stall;
      end
   end

   always_ff @(posedge clk) begin
      ex_op_a    <= rd_a;
      ex_op_b    <= rd_b;
      ex_imm     <= imm;
      ex_alu_op  <= alu_op;
      ex_use_imm <= use_imm;
      ex_dst     <= dst;
      ex_rs      <= rs_idx;
      ex_rt      <= rt_idx;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         err <= 1'b0;
      end else if (illegal) begin
         err <= 1'b1;
      end
   end

endmodule

/* execute.sv */
// operand forwarding, alu and the ex/mem register
`timescale 1ns/1ns

module execute import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     ex_valid,
   input  logic     ex_halt,
   input  word_t    ex_op_a,
   input  word_t    ex_op_b,
   input  word_t    ex_imm,
   input  alu_op_t  ex_alu_op,
   input  logic     ex_use_imm,
   input  logic     ex_mem_rd,
   input  logic     ex_mem_wr,
   input  logic     ex_we,
   input  reg_idx_t ex_dst,
   input  fwd_sel_t fwd_a,
   input  fwd_sel_t fwd_b,
   input  word_t    mem_fwd_data,
   input  word_t    wb_fwd_data,
   output logic     mem_valid,
   output logic     mem_halt,
   output word_t    mem_addr_data,
   output word_t    mem_store_data,
   output logic     mem_rd,
   output logic     mem_wr,
   output logic     mem_we,
   output reg_idx_t mem_dst
);

   word_t opnd_a;
   word_t opnd_b;
   word_t alu_b;
   word_t alu_out;

   function automatic word_t fwd_mux(
      input fwd_sel_t sel,
      input word_t    rf_val,
      input word_t    mem_val,
      input word_t    wb_val
   );
      case (sel)
         fwd_mem: return mem_val;
         fwd_wb:  return wb_val;
         default: return rf_val;
      endcase
   endfunction

   assign opnd_a = fwd_mux(fwd_a, ex_op_a, mem_fwd_data, wb_fwd_data);
   // store data takes this path too
   assign opnd_b = fwd_mux(fwd_b, ex_op_b, mem_fwd_data, wb_fwd_data);
   assign alu_b  = ex_use_imm ? ex_imm : opnd_b;

   // sub is rs minus rt
   always_comb begin
      case (ex_alu_op)
         alu_add: alu_out = opnd_a + alu_b;
         alu_sub: alu_out = opnd_a - alu_b;
         alu_xor: alu_out = opnd_a ^ alu_b;
         alu_and: alu_out = opnd_a & alu_b;
         default: alu_out = alu_b;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_valid <= 1'b0;
         mem_halt  <= 1'b0;
         mem_rd    <= 1'b0;
         mem_wr    <= 1'b0;
         mem_we    <= 1'b0;
      end else begin
         mem_valid <= ex_valid;
         mem_halt  <= ex_halt;
         mem_rd    <= ex_mem_rd;
         mem_wr    <= ex_mem_wr;
         mem_we    <= ex_we;
      end
   end

   always_ff @(posedge clk) begin
      mem_addr_data  <= alu_out;
      mem_store_data <= opnd_b;
      mem_dst        <= ex_dst;
   end

endmodule

/* fetch.sv */
// program counter, instruction memory, run control and the if/id register
`timescale 1ns/1ns
`include "cpu_macros.svh"

module fetch import cpu_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       run,
   input  logic       stall,
   input  logic       halt_retired,
   input  logic       imem_we,
   input  imem_addr_t apb_index,
   input  word_t      apb_wdata,
   output word_t      id_instr,
   output logic       id_valid,
   output logic       busy,
   output logic       halted
);

   word_t      imem [2**`IMEM_AW];
   imem_addr_t pc;
   run_state_t state;
   word_t      fetch_word;
   logic       fetch_halt;
   logic       issue;

   assign fetch_word = imem[pc];
   assign fetch_halt = (fetch_word[15:11] == `OP_HALT);
   assign issue      = (state == st_running) && !stall;

   assign busy   = (state == st_running) || (state == st_draining);
   assign halted = (state == st_halted);

   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[apb_index] <= apb_wdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= st_idle;
         pc    <= '0;
      end else begin
         // pc freezes on the halt word
         if (issue && !fetch_halt) begin
            pc <= pc + 1'b1;
         end
         case (state)
            st_idle: begin
               if (run) begin
                  state <= st_running;
               end
            end
            st_running: begin
               if (issue && fetch_halt) begin
                  state <= st_draining;
               end
            end
            st_draining: begin
               if (halt_retired) begin
                  state <= st_halted;
               end
            end
            default: state <= state;
         endcase
      end
   end

   // if/id, bubbles once the halt word has gone
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_valid <= 1'b0;
      end else if (!stall) begin
         id_valid <= (state == st_running);
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         id_instr <= fetch_word;
      end
   end

   a_pc_holds_on_stall : assert property (
      @(posedge clk) disable iff (!rst_n) stall |=> $stable(pc)
   ) else $error("fetch: pc moved during a stall cycle");

endmodule

/* hazard.sv */
// forwarding source selection and load-use stall detection
`timescale 1ns/1ns

module hazard import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t rs_idx,
   input  reg_idx_t rt_idx,
   input  logic     uses_rt,
   input  reg_idx_t ex_rs,
   input  reg_idx_t ex_rt,
   input  reg_idx_t ex_dst,
   input  logic     ex_mem_rd,
   input  logic     mem_we,
   input  reg_idx_t mem_dst,
   input  logic     wb_we,
   input  reg_idx_t wb_reg,
   output fwd_sel_t fwd_a,
   output fwd_sel_t fwd_b,
   output logic     stall
);

   // youngest producer wins
   function automatic fwd_sel_t src_sel(
      input reg_idx_t src,
      input logic     m_we,
      input reg_idx_t m_dst,
      input logic     w_we,
      input reg_idx_t w_dst
   );
      if (m_we && m_dst == src) begin
         return fwd_mem;
      end else if (w_we && w_dst == src) begin
         return fwd_wb;
      end
      return fwd_rf;
   endfunction

   assign fwd_a = src_sel(ex_rs, mem_we, mem_dst, wb_we, wb_reg);
   assign fwd_b = src_sel(ex_rt, mem_we, mem_dst, wb_we, wb_reg);

   // rs always compared, worst case one spare cycle
   assign stall = ex_mem_rd && ((ex_dst == rs_idx) || (uses_rt && ex_dst == rt_idx));

   a_stall_single_cycle : assert property (
      @(posedge clk) disable iff (!rst_n) stall |=> !stall
   ) else $error("hazard: stall held for two cycles");

endmodule

/* memory.sv */
// data memory, writeback select and the mem/wb register
`timescale 1ns/1ns
`include "cpu_macros.svh"

module memory import cpu_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       mem_valid,
   input  logic       mem_halt,
   input  word_t      mem_addr_data,
   input  word_t      mem_store_data,
   input  logic       mem_rd,
   input  logic       mem_wr,
   input  logic       mem_we,
   input  reg_idx_t   mem_dst,
   input  logic       dmem_we,
   input  dmem_addr_t apb_index,
   input  word_t      apb_wdata,
   output word_t      dmem_rdata,
   output logic       wb_we,
   output reg_idx_t   wb_reg,
   output word_t      wb_data,
   output logic       halt_retired
);

   word_t      dmem [2**`DMEM_AW];
   dmem_addr_t idx;
   word_t      load_data;
   logic       wb_valid;
   logic       wb_we_q;

   assign idx        = mem_addr_data[`DMEM_AW-1:0];
   assign load_data  = dmem[idx];
   assign dmem_rdata = dmem[apb_index];

   // bus writes only happen while the pipe is empty
   always_ff @(posedge clk) begin
      if (mem_valid && mem_wr) begin
         dmem[idx] <= mem_store_data;
      end else if (dmem_we) begin
         dmem[apb_index] <= apb_wdata;
      end
   end

   // stores ahead of the marker are already done
   assign halt_retired = mem_valid & mem_halt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
         wb_we_q  <= 1'b0;
      end else begin
         wb_valid <= mem_valid & ~mem_halt;
         wb_we_q  <= mem_we;
      end
   end

   always_ff @(posedge clk) begin
      wb_reg  <= mem_dst;
      wb_data <= mem_rd ? load_data : mem_addr_data;
   end

   assign wb_we = wb_valid & wb_we_q;

endmodule

/* proc.sv */
// pipelined 16-bit cpu core with an apb port for loading and reading memory
`timescale 1ns/1ns
`include "cpu_macros.svh"

module proc import cpu_pkg::*; (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               run,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [`APB_AW-1:0] paddr,
   input  word_t              pwdata,
   output word_t              prdata,
   output logic               pready,
   output logic               pslverr,
   output logic               halted,
   output logic               err
);

   // apb side
   logic       busy;
   logic       imem_we;
   logic       dmem_we;
   imem_addr_t apb_index;
   word_t      apb_wdata;
   word_t      dmem_rdata;

   // if/id
   word_t      id_instr;
   logic       id_valid;

   reg_idx_t   rs_idx;
   reg_idx_t   rt_idx;
   logic       uses_rt;

   // id/ex
   logic       ex_valid;
   logic       ex_halt;
   word_t      ex_op_a;
   word_t      ex_op_b;
   word_t      ex_imm;
   alu_op_t    ex_alu_op;
   logic       ex_use_imm;
   logic       ex_mem_rd;
   logic       ex_mem_wr;
   logic       ex_we;
   reg_idx_t   ex_dst;
   reg_idx_t   ex_rs;
   reg_idx_t   ex_rt;

   // ex/mem
   logic       mem_valid;
   logic       mem_halt;
   word_t      mem_addr_data;
   word_t      mem_store_data;
   logic       mem_rd;
   logic       mem_wr;
   logic       mem_we;
   reg_idx_t   mem_dst;

   // mem/wb
   logic       wb_we;
   reg_idx_t   wb_reg;
   word_t      wb_data;
   logic       halt_retired;

   fwd_sel_t   fwd_a;
   fwd_sel_t   fwd_b;
   logic       stall;

   apb_port i_apb (.*);

   fetch i_fetch (.*);

   decode i_decode (.*);

   execute i_execute (
      .mem_fwd_data (mem_addr_data),
      .wb_fwd_data  (wb_data),
      .*
   );

   memory i_memory (.*);

   hazard i_hazard (.*);

endmodule

/* src.f */
+incdir+.
cpu_pkg.sv
apb_port.sv
fetch.sv
decode.sv
execute.sv
memory.sv
hazard.sv
proc.sv
tb_proc.sv

/* tb_proc.sv */
// testbench for the pipelined cpu core, checks data memory against an isa model
`timescale 1ns/1ns
`include "cpu_macros.svh"

module tb_proc import cpu_pkg::*; ();

   localparam int CLK_PERIOD = 8;
   localparam int N_RANDOM   = 10;
   localparam int RAND_LEN   = 30;
   localparam int MAX_WORDS  = 64;
   localparam int N_PROGS    = N_RANDOM + 3;
   // bus check plus every program, each with its own allowance
   localparam int WATCHDOG_CYCLES = (N_PROGS + 1) * (20 * MAX_WORDS + 2000);

   logic         clk;
   logic         rst_n;
   logic         run;
   logic         psel;
   logic         penable;
   logic         pwrite;
   logic [8:0]   paddr;
   word_t        pwdata;
   word_t        prdata;
   logic         pready;
   logic         pslverr;
   logic         halted;
   logic         err;

   word_t        prog [256];
   int           plen;
   word_t        model_rf [8];
   word_t        model_mem [256];
   logic [31:0]  rng;
   int           errors;
   int           checks;

   proc i_dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic word_t enc_imm5(input logic [4:0] op, input logic [2:0] rs,
                                      input logic [2:0] rt, input logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t enc_lbi(input logic [2:0] rs, input logic [7:0] imm);
      return {`OP_LBI, rs, imm};
   endfunction

   function automatic word_t enc_alu(input logic [2:0] rs, input logic [2:0] rt,
                                     input logic [2:0] rd, input logic [1:0] fn);
      return {`OP_ALU, rs, rt, rd, fn};
   endfunction

   // runs prog in order on model_rf and model_mem, returns 1 if an illegal word was seen
   function automatic logic run_model(input int len);
      word_t ins;
      word_t a;
      word_t b;
      word_t ea;
      logic  bad;
      int    pc;
      bad = 1'b0;
      for (pc = 0; pc < len; pc++) begin
         ins = prog[pc[7:0]];
         a   = model_rf[ins[10:8]];
         b   = model_rf[ins[7:5]];
         ea  = a + {{11{ins[4]}}, ins[4:0]};
         case (ins[15:11])
            `OP_HALT: return bad;
            `OP_NOP: ;
            `OP_ADDI: model_rf[ins[7:5]] = ea;
            `OP_LD: model_rf[ins[7:5]] = model_mem[ea[7:0]];
            `OP_ST: model_mem[ea[7:0]] = b;
            `OP_LBI: model_rf[ins[10:8]] = {{8{ins[7]}}, ins[7:0]};
            `OP_ALU: begin
               case (ins[1:0])
                  2'b00: model_rf[ins[4:2]] = a + b;
                  2'b01: model_rf[ins[4:2]] = a - b;
                  2'b10: model_rf[ins[4:2]] = a ^ b;
                  default: model_rf[ins[4:2]] = a & b;
               endcase
            end
            default: bad = 1'b1;
         endcase
      end
      return bad;
   endfunction

   task automatic check_value(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic apb_xfer(input logic wr, input logic [8:0] addr, input word_t wdata,
                           output word_t rdata, output logic slverr);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      rdata  = prdata;
      slverr = pslverr;
      check_value("pready", {15'b0, pready}, 16'h0001);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      run   = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      check_value("halted", {15'b0, halted}, 16'h0000);
      check_value("err", {15'b0, err}, 16'h0000);
      check_value("pslverr", {15'b0, pslverr}, 16'h0000);
   endtask

   // pattern covers all eight address bits
   task automatic fill_dmem(input logic [7:0] tag);
      word_t rdata;
      logic  slverr;
      word_t val;
      int    i;
      for (i = 0; i < 256; i++) begin
         val = {i[7:0], ~i[7:0]} ^ {tag, tag};
         model_mem[i[7:0]] = val;
         apb_xfer(1'b1, {1'b1, i[7:0]}, val, rdata, slverr);
         check_value("pslverr", {15'b0, slverr}, 16'h0000);
      end
   endtask

   task automatic compare_dmem();
      word_t rdata;
      logic  slverr;
      int    i;
      for (i = 0; i < 256; i++) begin
         apb_xfer(1'b0, {1'b1, i[7:0]}, '0, rdata, slverr);
         check_value("pslverr", {15'b0, slverr}, 16'h0000);
         check_value($sformatf("dmem[%02h]", i[7:0]), rdata, model_mem[i[7:0]]);
      end
   endtask

   task automatic emit(input word_t w);
      prog[plen[7:0]] = w;
      plen++;
   endtask

   task automatic draw(output logic [31:0] r);
      rng = xorshift32(rng);
      r   = rng;
   endtask

   task automatic emit_init_regs();
      logic [31:0] r;
      int          i;
      for (i = 0; i < 8; i++) begin
         draw(r);
         emit(enc_lbi(i[2:0], r[7:0]));
      end
   endtask

   // r7 down to r0 at r0 plus register number, then halt
   task automatic emit_store_all_halt();
      int r;
      for (r = 7; r >= 0; r--) begin
         emit(enc_imm5(`OP_ST, 3'd0, r[2:0], {2'b00, r[2:0]}));
      end
      emit(16'h0000);
   endtask

   task automatic draw_instr(output word_t w);
      logic [31:0] r;
      logic [4:0]  op;
      draw(r);
      case (r[31:29])
         3'd0: op = `OP_NOP;
         3'd1: op = `OP_ADDI;
         3'd2: op = `OP_LBI;
         3'd3: op = `OP_ST;
         3'd4, 3'd7: op = `OP_LD;
         default: op = `OP_ALU;
      endcase
      w = {op, r[10:0]};
   endtask

   task automatic run_program(input logic [7:0] tag, input logic poke_busy);
      logic  exp_err;
      word_t rdata;
      logic  slverr;
      word_t dummy;
      int    i;
      apply_reset();
      for (i = 0; i < plen; i++) begin
         apb_xfer(1'b1, {1'b0, i[7:0]}, prog[i[7:0]], dummy, slverr);
      end
      fill_dmem(tag);
      exp_err = run_model(plen);
      @(posedge clk);
      #1;
      run = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b0;
      // core is busy now, both accesses must bounce
      if (poke_busy) begin
         apb_xfer(1'b1, {1'b1, 8'h00}, 16'hdead, rdata, slverr);
         check_value("pslverr", {15'b0, slverr}, 16'h0001);
         apb_xfer(1'b0, {1'b1, 8'h00}, '0, rdata, slverr);
         check_value("pslverr", {15'b0, slverr}, 16'h0001);
      end
      while (!halted) @(negedge clk);
      check_value("err", {15'b0, err}, {15'b0, exp_err});
      compare_dmem();
   endtask

   initial begin
      int          p;
      int          k;
      word_t       w;
      clk     = 1'b0;
      rst_n   = 1'b0;
      run     = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      errors  = 0;
      checks  = 0;
      plen    = 0;
      rng     = 32'hae8440be;

      // bus only, idle core
      apply_reset();
      fill_dmem(8'h00);
      compare_dmem();

      // dependent chain through every alu function
      plen = 0;
      emit(enc_lbi(3'd0, 8'hc4));
      emit(enc_imm5(`OP_ADDI, 3'd0, 3'd1, 5'd5));
      emit(enc_alu(3'd1, 3'd0, 3'd2, 2'b00));
      emit(enc_alu(3'd2, 3'd1, 3'd3, 2'b01));
      emit(enc_alu(3'd3, 3'd2, 3'd4, 2'b10));
      emit(enc_alu(3'd4, 3'd3, 3'd5, 2'b11));
      emit(enc_imm5(`OP_ADDI, 3'd5, 3'd6, 5'h1f));
      emit(enc_alu(3'd6, 3'd5, 3'd7, 2'b00));
      emit_store_all_halt();
      run_program(8'h01, 1'b0);

      // load-use on rs and on store data
      plen = 0;
      emit_init_regs();
      emit(enc_lbi(3'd1, 8'h20));
      emit(enc_imm5(`OP_LD, 3'd1, 3'd3, 5'd2));
      emit(enc_alu(3'd3, 3'd2, 3'd4, 2'b00));
      emit(enc_imm5(`OP_ST, 3'd1, 3'd4, 5'd3));
      emit(enc_imm5(`OP_LD, 3'd1, 3'd5, 5'd3));
      emit(enc_imm5(`OP_ST, 3'd1, 3'd5, 5'd4));
      emit(enc_imm5(`OP_LD, 3'd1, 3'd6, 5'd5));
      emit(enc_alu(3'd2, 3'd6, 3'd7, 2'b01));
      emit_store_all_halt();
      run_program(8'h02, 1'b1);

      // opcode 00111 is not in the set
      plen = 0;
      emit_init_regs();
      emit(enc_imm5(`OP_ADDI, 3'd0, 3'd1, 5'd3));
      emit(16'h3a5c);
      emit(enc_alu(3'd1, 3'd1, 3'd2, 2'b00));
      emit(enc_lbi(3'd3, 8'h7e));
      emit_store_all_halt();
      run_program(8'h03, 1'b0);

      for (p = 0; p < N_RANDOM; p++) begin
         plen = 0;
         emit_init_regs();
         for (k = 0; k < RAND_LEN; k++) begin
            draw_instr(w);
            emit(w);
         end
         emit_store_all_halt();
         run_program(p[7:0] + 8'h10, 1'b0);
      end

      $display("checks run %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, halted never rose", WATCHDOG_CYCLES);
      $display("TB FAILED");
      $finish;
   end

endmodule
